//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_lsu
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/lsu_pkg.sv
/*
  Load/store unit core definitions
  Operation codes, data widths, exception causes and the request,
  control and result structs shared by the LSU pipeline stages
*/
`default_nettype none

package lsu_pkg;

  localparam int XLEN       = 32;
  localparam int TRANS_ID_W = 3;

  // RISC-V exception causes
  localparam logic [XLEN-1:0] CAUSE_LD_MISALIGNED = 4;
  localparam logic [XLEN-1:0] CAUSE_ST_MISALIGNED = 6;

  typedef enum logic [2:0] {
    LB,
    LBU,
    LH,
    LHU,
    LW,
    SB,
    SH,
    SW
  } lsu_op_e;

  typedef struct packed {
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [XLEN-1:0]       imm;
    lsu_op_e               op;
    logic [TRANS_ID_W-1:0] trans_id;
  } lsu_req_t;

  typedef struct packed {
    logic [XLEN-1:0]       vaddr;
    logic [XLEN-1:0]       wdata;
    logic [XLEN/8-1:0]     be;
    lsu_op_e               op;
    logic [TRANS_ID_W-1:0] trans_id;
  } lsu_ctrl_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] cause;
    logic [XLEN-1:0] tval;
  } exception_t;

  typedef struct packed {
    logic                  valid;
    logic [TRANS_ID_W-1:0] trans_id;
    logic [XLEN-1:0]       data;
    exception_t            ex;
  } lsu_result_t;

  // Transfer size as log2 of bytes
  function automatic logic [1:0] op_size(lsu_op_e op);
    case (op)
      LB, LBU, SB: return 2'd0;
      LH, LHU, SH: return 2'd1;
      default:     return 2'd2;
    endcase
  endfunction

  function automatic logic op_is_store(lsu_op_e op);
    return (op == SB) || (op == SH) || (op == SW);
  endfunction

endpackage

`default_nettype wire

//--- common/mem_pkg.sv
/*
  Data memory port definitions
  Word-addressed request and response structs and the width of
  the credit counter used for flow control on the port
*/
`default_nettype none

package mem_pkg;

  localparam int DATA_W   = 32;
  localparam int WADDR_W  = 30;
  localparam int CREDIT_W = 3;

  // One request per credit, stores get no response
  typedef struct packed {
    logic                valid;
    logic                we;
    logic [WADDR_W-1:0]  addr;
    logic [DATA_W-1:0]   wdata;
    logic [DATA_W/8-1:0] be;
  } mem_req_t;

  // Load data, returned in request order
  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

//--- dv/lsu_assertions.sv
/*
  Memory issue stage checks
  Credit bounds, request gating by credits and quiet results in reset
*/
`timescale 1ns/10ps
`default_nettype none

module lsu_assertions #(
  parameter int unsigned NUM_CREDITS = 2
) (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic [mem_pkg::CREDIT_W-1:0] credit_i,
  input logic                         credit_ret_i,
  input logic                         req_valid_i,
  input logic                         ld_valid_i,
  input logic                         st_valid_i
);

  logic [31:0] credit_ext;

  assign credit_ext = 32'(credit_i);

  // ----------------------------------------
  // Credit rules
  // ----------------------------------------
  credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_ext <= NUM_CREDITS)
    else $error("credit count %0d above %0d", credit_ext, NUM_CREDITS);

  req_needs_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i |-> credit_ext != 32'd0)
    else $error("memory request issued with no credit left");

  // A returned credit must have been taken before
  credit_return: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (credit_ret_i && !req_valid_i) |-> credit_ext < NUM_CREDITS)
    else $error("credit returned while the counter was full");

  reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> !ld_valid_i && !st_valid_i)
    else $error("result valid during reset");

endmodule

bind lsu_mem_issue lsu_assertions #(
  .NUM_CREDITS (NUM_CREDITS)
) u_assertions (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .credit_i     (credit_q),
  .credit_ret_i (mem_credit_i),
  .req_valid_i  (mem_req_o.valid),
  .ld_valid_i   (ld_result_o.valid),
  .st_valid_i   (st_result_o.valid)
);

`default_nettype wire

//--- dv/tb_lsu.sv
/*
  Load/store unit testbench
  Drives directed and random load/store sequences into the LSU, models
  a credit-based data memory with random response delays and checks
  every load and store result against a reference memory
*/
`timescale 1ns/10ps
`default_nettype none

module tb_lsu;
  import lsu_pkg::*;
  import mem_pkg::*;

  localparam int NUM_CREDITS = 2;
  localparam int RAND_OPS    = 60;

  // Cycle budget of each test
  localparam int T_STORE_LOAD   = 100;
  localparam int T_SUBWORD      = 200;
  localparam int T_MISALIGN     = 150;
  localparam int T_BACKPRESSURE = 300;
  localparam int T_RANDOM       = RAND_OPS * 20;
  localparam int WATCHDOG_CYCLES =
    4 * (T_STORE_LOAD + T_SUBWORD + T_MISALIGN + T_BACKPRESSURE + T_RANDOM);

  logic        clk_i;
  logic        rst_ni;
  logic        lsu_valid_i;
  lsu_req_t    lsu_req_i;
  logic        lsu_ready_o;
  mem_req_t    mem_req_o;
  mem_rsp_t    mem_rsp_i;
  logic        mem_credit_i;
  lsu_result_t load_result_o;
  lsu_result_t store_result_o;

  // Memory model state
  logic [31:0] model_mem [256];
  logic [31:0] rsp_data_q [$];
  int          rsp_due_q [$];
  int          credit_due_q [$];
  int          last_rsp_due;
  int          cycle;
  int          mem_req_count;
  logic        hold_credits;

  // Reference side
  logic [31:0]           ref_mem [256];
  lsu_result_t           exp_ld_q [$];
  lsu_result_t           exp_st_q [$];
  logic [TRANS_ID_W-1:0] next_tid;
  string                 cur_test;
  int                    check_errors;
  int                    other_errors;

  lsu_top #(
    .NUM_CREDITS      (NUM_CREDITS),
    .LOAD_PIPE_DEPTH  (1),
    .STORE_PIPE_DEPTH (0)
  ) u_dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lsu_valid_i    (lsu_valid_i),
    .lsu_req_i      (lsu_req_i),
    .lsu_ready_o    (lsu_ready_o),
    .mem_req_o      (mem_req_o),
    .mem_rsp_i      (mem_rsp_i),
    .mem_credit_i   (mem_credit_i),
    .load_result_o  (load_result_o),
    .store_result_o (store_result_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Start contents of a word, a function of its full word address
  function automatic logic [31:0] fill_word(int idx);
    logic [7:0] a;
    a = idx[7:0];
    return {a ^ 8'h5a, ~a, a + 8'h31, a};
  endfunction

  // ----------------------------------------
  // Checking
  // ----------------------------------------
  task automatic check(string what, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s: %s expected %h actual %h", cur_test, what, expected, actual);
      check_errors++;
    end
  endtask

  task automatic compare_result(string kind, lsu_result_t exp, lsu_result_t act);
    check({kind, " trans_id"}, 32'(exp.trans_id), 32'(act.trans_id));
    check({kind, " data"}, exp.data, act.data);
    check({kind, " exception"}, 32'(exp.ex.valid), 32'(act.ex.valid));
    check({kind, " cause"}, exp.ex.cause, act.ex.cause);
    check({kind, " tval"}, exp.ex.tval, act.ex.tval);
  endtask

  // Sign or zero extension of the addressed byte or halfword
  function automatic logic [31:0] extend_load(lsu_op_e op, logic [31:0] word, logic [1:0] off);
    logic [31:0] shifted;
    logic [7:0]  b;
    logic [15:0] h;
    shifted = word >> (8 * off);
    b = shifted[7:0];
    h = shifted[15:0];
    case (op)
      LB:      return {{24{b[7]}}, b};
      LBU:     return {24'h0, b};
      LH:      return {{16{h[15]}}, h};
      LHU:     return {16'h0, h};
      default: return word;
    endcase
  endfunction

  task automatic write_ref(lsu_op_e op, int idx, logic [1:0] off, logic [31:0] data);
    case (op)
      SB:      ref_mem[idx][8*off +: 8] = data[7:0];
      SH:      ref_mem[idx][16*off[1] +: 16] = data[15:0];
      default: ref_mem[idx] = data;
    endcase
  endtask

  // Predict the result, then hold the request until the LSU takes it
  task automatic issue(lsu_op_e op, logic [31:0] base, logic [31:0] imm, logic [31:0] data);
    lsu_result_t exp;
    logic [31:0] vaddr;
    logic [1:0]  off;
    logic        is_st;
    logic        mis;
    logic        accepted;
    int          idx;
    vaddr = base + imm;
    off   = vaddr[1:0];
    idx   = int'(vaddr[9:2]);
    is_st = (op == SB) || (op == SH) || (op == SW);
    mis   = ((op == LH || op == LHU || op == SH) && vaddr[0]) ||
            ((op == LW || op == SW) && off != 2'd0);
    exp = '0;
    exp.valid    = 1'b1;
    exp.trans_id = next_tid;
    if (mis) begin
      exp.ex.valid = 1'b1;
      exp.ex.cause = is_st ? 32'd6 : 32'd4;
      exp.ex.tval  = vaddr;
    end else if (is_st) begin
      write_ref(op, idx, off, data);
    end else begin
      exp.data = extend_load(op, ref_mem[idx], off);
    end
    if (is_st) begin
      exp_st_q.push_back(exp);
    end else begin
      exp_ld_q.push_back(exp);
    end
    lsu_req_i.operand_a = base;
    lsu_req_i.operand_b = data;
    lsu_req_i.imm       = imm;
    lsu_req_i.op        = op;
    lsu_req_i.trans_id  = next_tid;
    lsu_valid_i         = 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk_i);
      accepted = lsu_ready_o;
      @(posedge clk_i);
      #1;
    end
    lsu_valid_i = 1'b0;
    next_tid++;
  endtask

  task automatic wait_idle(int limit);
    int n;
    n = 0;
    while ((exp_ld_q.size() != 0 || exp_st_q.size() != 0) && n < limit) begin
      @(posedge clk_i);
      #1;
      n++;
    end
    if (exp_ld_q.size() != 0 || exp_st_q.size() != 0) begin
      $display("ERROR %s: %0d load and %0d store results still missing after %0d cycles",
               cur_test, exp_ld_q.size(), exp_st_q.size(), limit);
      other_errors++;
      exp_ld_q.delete();
      exp_st_q.delete();
    end
  endtask

  // ----------------------------------------
  // Memory model and result monitor
  // ----------------------------------------
  initial begin : mem_accept
    int due;
    mem_req_count = 0;
    last_rsp_due  = 0;
    for (int i = 0; i < 256; i++) begin
      model_mem[i] = fill_word(i);
    end
    forever begin
      @(negedge clk_i);
      if (rst_ni && mem_req_o.valid) begin
        mem_req_count++;
        if (mem_req_o.we) begin
          for (int b = 0; b < 4; b++) begin
            if (mem_req_o.be[b]) begin
              model_mem[mem_req_o.addr[7:0]][b*8 +: 8] = mem_req_o.wdata[b*8 +: 8];
            end
          end
          credit_due_q.push_back(cycle + 1 + int'($urandom_range(0, 3)));
        end else begin
          // Responses leave in request order, at most one per cycle
          due = cycle + 1 + int'($urandom_range(0, 3));
          if (due <= last_rsp_due) begin
            due = last_rsp_due + 1;
          end
          last_rsp_due = due;
          rsp_data_q.push_back(model_mem[mem_req_o.addr[7:0]]);
          rsp_due_q.push_back(due);
          credit_due_q.push_back(due);
        end
      end
      if (rst_ni && load_result_o.valid) begin
        if (exp_ld_q.size() == 0) begin
          $display("ERROR %s: load result with trans_id %0d arrived while none was pending",
                   cur_test, load_result_o.trans_id);
          other_errors++;
        end else begin
          compare_result("load", exp_ld_q.pop_front(), load_result_o);
        end
      end
      if (rst_ni && store_result_o.valid) begin
        if (exp_st_q.size() == 0) begin
          $display("ERROR %s: store result with trans_id %0d arrived while none was pending",
                   cur_test, store_result_o.trans_id);
          other_errors++;
        end else begin
          compare_result("store", exp_st_q.pop_front(), store_result_o);
        end
      end
    end
  end

  initial begin : mem_driver
    mem_rsp_i    = '0;
    mem_credit_i = 1'b0;
    cycle        = 0;
    forever begin
      @(posedge clk_i);
      cycle++;
      #1;
      mem_rsp_i    = '0;
      mem_credit_i = 1'b0;
      if (rsp_due_q.size() != 0 && rsp_due_q[0] <= cycle) begin
        mem_rsp_i.valid = 1'b1;
        mem_rsp_i.rdata = rsp_data_q.pop_front();
        void'(rsp_due_q.pop_front());
      end
      // One credit back per cycle
      if (!hold_credits && credit_due_q.size() != 0 && credit_due_q[0] <= cycle) begin
        mem_credit_i = 1'b1;
        void'(credit_due_q.pop_front());
      end
    end
  end

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic check_reset_state();
    cur_test = "reset";
    check("ready", 32'd1, 32'(lsu_ready_o));
    check("memory request valid", 32'd0, 32'(mem_req_o.valid));
    check("load result valid", 32'd0, 32'(load_result_o.valid));
    check("store result valid", 32'd0, 32'(store_result_o.valid));
    check("credits", NUM_CREDITS, 32'(u_dut.u_issue.credit_q));
  endtask

  task automatic test_store_load();
    cur_test = "store_load";
    issue(SW, 32'h110, 32'hFFFF_FFF0, 32'hDEAD_BEEF);
    issue(LW, 32'h0F0, 32'h10, 32'h0);
    issue(SW, 32'h204, 32'h0, 32'h1234_5678);
    issue(LW, 32'h208, 32'hFFFF_FFFC, 32'h0);
    wait_idle(T_STORE_LOAD);
  endtask

  task automatic test_subword();
    cur_test = "subword";
    issue(SW, 32'h300, 32'h0, 32'h0);
    issue(SH, 32'h300, 32'h2, 32'hABCD_8001);
    issue(SB, 32'h300, 32'h0, 32'h1111_1185);
    issue(SB, 32'h300, 32'h1, 32'h2222_227F);
    issue(LB, 32'h300, 32'h0, 32'h0);
    issue(LBU, 32'h300, 32'h0, 32'h0);
    issue(LB, 32'h300, 32'h1, 32'h0);
    issue(LB, 32'h300, 32'h3, 32'h0);
    issue(LBU, 32'h300, 32'h3, 32'h0);
    issue(LH, 32'h300, 32'h0, 32'h0);
    issue(LH, 32'h300, 32'h2, 32'h0);
    issue(LHU, 32'h300, 32'h2, 32'h0);
    issue(LW, 32'h300, 32'h0, 32'h0);
    wait_idle(T_SUBWORD);
  endtask

  task automatic test_misaligned();
    int reqs_before;
    cur_test = "misaligned";
    reqs_before = mem_req_count;
    issue(LH, 32'h3C1, 32'h0, 32'h0);
    issue(SH, 32'h3C3, 32'h0, 32'h1111_2222);
    issue(LW, 32'h3C0, 32'h2, 32'h0);
    issue(SW, 32'h3C8, 32'hFFFF_FFFF, 32'h3333_4444);
    issue(LHU, 32'h3D5, 32'h0, 32'h0);
    wait_idle(T_MISALIGN);
    check("memory requests", reqs_before, mem_req_count);
  endtask

  task automatic test_backpressure();
    logic saw_full;
    int   n;
    cur_test = "backpressure";
    hold_credits = 1'b1;
    saw_full = 1'b0;
    fork
      begin
        issue(LW, 32'h080, 32'h0, 32'h0);
        issue(SW, 32'h084, 32'h0, 32'hCAFE_F00D);
        issue(LW, 32'h084, 32'h0, 32'h0);
        issue(LBU, 32'h087, 32'h0, 32'h0);
        issue(SW, 32'h088, 32'h0, 32'h0BAD_1DEA);
        issue(LW, 32'h088, 32'h0, 32'h0);
        issue(LH, 32'h08A, 32'h0, 32'h0);
        issue(LW, 32'h080, 32'h0, 32'h0);
      end
      begin
        n = 0;
        while (!saw_full && n < 100) begin
          @(negedge clk_i);
          saw_full = !lsu_ready_o;
          n++;
        end
        repeat (10) @(posedge clk_i);
        hold_credits = 1'b0;
      end
    join
    check("ready fell while credits were held", 32'd1, 32'(saw_full));
    wait_idle(T_BACKPRESSURE);
  endtask

  task automatic test_random();
    lsu_op_e     op;
    logic [1:0]  off;
    logic [31:0] addr;
    int          word_idx;
    cur_test = "random";
    for (int i = 0; i < RAND_OPS; i++) begin
      word_idx = int'($urandom_range(0, 63));
      op = lsu_op_e'($urandom_range(0, 7));
      case (op)
        LH, LHU, SH: off = 2'($urandom_range(0, 1) * 2);
        LW, SW:      off = 2'd0;
        default:     off = 2'($urandom_range(0, 3));
      endcase
      addr = 32'(word_idx * 4) + 32'(off);
      issue(op, addr + 32'h40, 32'hFFFF_FFC0, $urandom());
      // Occasional gap in the request stream
      if ($urandom_range(0, 3) == 0) begin
        @(posedge clk_i);
        #1;
      end
    end
    wait_idle(T_RANDOM);
  endtask

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : main
    void'($urandom(32'ha7b6));
    rst_ni       = 1'b0;
    lsu_valid_i  = 1'b0;
    lsu_req_i    = '0;
    hold_credits = 1'b0;
    next_tid     = '0;
    check_errors = 0;
    other_errors = 0;
    cur_test     = "reset";
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = fill_word(i);
    end
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    check_reset_state();
    test_store_load();
    test_subword();
    test_misaligned();
    test_backpressure();
    test_random();
    repeat (10) @(posedge clk_i);
    $display("Check errors: %0d, other errors: %0d", check_errors, other_errors);
    if (check_errors == 0 && other_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
common/lsu_pkg.sv
common/mem_pkg.sv
source/lsu_agu.sv
source/lsu_ctrl_queue.sv
source/lsu_addr_xlate.sv
mem_port/lsu_mem_issue.sv
source/lsu_result_pipe.sv
source/lsu_top.sv
dv/lsu_assertions.sv
dv/tb_lsu.sv

//--- mem_port/lsu_mem_issue.sv
/*
  Memory issue stage
  Sends loads and stores to the data memory port under credit flow
  control, tracks outstanding loads in order and extends load data
*/
`timescale 1ns/10ps
`default_nettype none

module lsu_mem_issue #(
  parameter int unsigned NUM_CREDITS = 2
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     xlate_valid_i,
  input  lsu_pkg::lsu_ctrl_t       ctrl_i,
  input  logic [lsu_pkg::XLEN-1:0] paddr_i,
  input  lsu_pkg::exception_t      ex_i,
  output logic                     issue_ready_o,
  output mem_pkg::mem_req_t        mem_req_o,
  input  mem_pkg::mem_rsp_t        mem_rsp_i,
  input  logic                     mem_credit_i,
  output lsu_pkg::lsu_result_t     ld_result_o,
  output lsu_pkg::lsu_result_t     st_result_o
);
  import lsu_pkg::*;
  import mem_pkg::*;

  localparam int PTR_W = (NUM_CREDITS > 1) ? $clog2(NUM_CREDITS) : 1;

  typedef struct packed {
    logic [TRANS_ID_W-1:0] trans_id;
    logic [1:0]            offset;
    lsu_op_e               op;
  } ld_entry_t;

  logic [CREDIT_W-1:0] credit_q;
  ld_entry_t           lq_q [NUM_CREDITS];
  logic [PTR_W-1:0]    lq_rd_q;
  logic [PTR_W-1:0]    lq_wr_q;
  logic [CREDIT_W-1:0] lq_cnt_q;
  ld_entry_t           lq_head;
  logic                is_st;
  logic                can_issue;
  logic                req_fire;
  logic                lq_push;
  logic [XLEN-1:0]     rsp_word;
  logic [XLEN-1:0]     ld_data;

  assign is_st   = op_is_store(ctrl_i.op);
  assign lq_head = lq_q[lq_rd_q];

  // ----------------------------------------
  // Issue decision
  // ----------------------------------------
  always_comb begin
    if (ex_i.valid) begin
      // Faulting loads wait for older loads to keep result order
      can_issue = is_st || (lq_cnt_q == '0);
    end else if (is_st) begin
      can_issue = (credit_q != '0);
    end else begin
      can_issue = (credit_q != '0) && (lq_cnt_q != CREDIT_W'(NUM_CREDITS));
    end
  end

  assign issue_ready_o = xlate_valid_i && can_issue;
  assign req_fire      = issue_ready_o && !ex_i.valid;
  assign lq_push       = req_fire && !is_st;

  always_comb begin
    mem_req_o.valid = req_fire;
    mem_req_o.we    = is_st;
    mem_req_o.addr  = paddr_i[XLEN-1:2];
    mem_req_o.wdata = ctrl_i.wdata;
    mem_req_o.be    = ctrl_i.be;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= CREDIT_W'(NUM_CREDITS);
      lq_rd_q  <= '0;
      lq_wr_q  <= '0;
      lq_cnt_q <= '0;
    end else begin
      case ({req_fire, mem_credit_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
      if (lq_push) begin
        lq_wr_q <= (lq_wr_q == PTR_W'(NUM_CREDITS - 1)) ? '0 : lq_wr_q + 1'b1;
      end
      if (mem_rsp_i.valid) begin
        lq_rd_q <= (lq_rd_q == PTR_W'(NUM_CREDITS - 1)) ? '0 : lq_rd_q + 1'b1;
      end
      case ({lq_push, mem_rsp_i.valid})
        2'b10:   lq_cnt_q <= lq_cnt_q + 1'b1;
        2'b01:   lq_cnt_q <= lq_cnt_q - 1'b1;
        default: lq_cnt_q <= lq_cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (lq_push) begin
      lq_q[lq_wr_q] <= '{trans_id: ctrl_i.trans_id, offset: paddr_i[1:0], op: ctrl_i.op};
    end
  end

  // ----------------------------------------
  // Load data extension
  // ----------------------------------------
  always_comb begin
    rsp_word = mem_rsp_i.rdata >> {lq_head.offset, 3'b000};
    case (lq_head.op)
      LB:      ld_data = {{(XLEN-8){rsp_word[7]}}, rsp_word[7:0]};
      LBU:     ld_data = {{(XLEN-8){1'b0}}, rsp_word[7:0]};
      LH:      ld_data = {{(XLEN-16){rsp_word[15]}}, rsp_word[15:0]};
      LHU:     ld_data = {{(XLEN-16){1'b0}}, rsp_word[15:0]};
      default: ld_data = rsp_word;
    endcase
  end

  always_comb begin
    ld_result_o = '0;
    if (mem_rsp_i.valid) begin
      ld_result_o.valid    = 1'b1;
      ld_result_o.trans_id = lq_head.trans_id;
      ld_result_o.data     = ld_data;
    end else if (issue_ready_o && !is_st && ex_i.valid) begin
      ld_result_o.valid    = 1'b1;
      ld_result_o.trans_id = ctrl_i.trans_id;
      ld_result_o.ex       = ex_i;
    end
  end

  // Stores complete as soon as they are issued
  always_comb begin
    st_result_o          = '0;
    st_result_o.valid    = issue_ready_o && is_st;
    st_result_o.trans_id = ctrl_i.trans_id;
    st_result_o.ex       = ex_i;
  end

endmodule

`default_nettype wire

//--- source/lsu_addr_xlate.sv
/*
  Address translation stage without MMU
  One register stage that maps the virtual address to the same
  physical address and attaches a misaligned-address exception
*/
`timescale 1ns/10ps
`default_nettype none

module lsu_addr_xlate (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       head_valid_i,
  input  lsu_pkg::lsu_ctrl_t         head_i,
  output logic                       pop_o,
  input  logic                       issue_ready_i,
  output logic                       xlate_valid_o,
  output lsu_pkg::lsu_ctrl_t         ctrl_o,
  output logic [lsu_pkg::XLEN-1:0]   paddr_o,
  output lsu_pkg::exception_t        ex_o
);
  import lsu_pkg::*;

  logic       misaligned;
  exception_t ex_d;

  // ----------------------------------------
  // Misalignment check
  // ----------------------------------------
  always_comb begin
    case (op_size(head_i.op))
      2'd1:    misaligned = head_i.vaddr[0];
      2'd2:    misaligned = |head_i.vaddr[1:0];
      // Bytes are always aligned
      default: misaligned = 1'b0;
    endcase
  end

  always_comb begin
    ex_d = '0;
    if (misaligned) begin
      ex_d.valid = 1'b1;
      ex_d.cause = op_is_store(head_i.op) ? CAUSE_ST_MISALIGNED : CAUSE_LD_MISALIGNED;
      ex_d.tval  = head_i.vaddr;
    end
  end

  // Take a new entry when the register is free or drains this cycle
  assign pop_o = head_valid_i && (!xlate_valid_o || issue_ready_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      xlate_valid_o <= 1'b0;
    end else if (pop_o) begin
      xlate_valid_o <= 1'b1;
    end else if (issue_ready_i) begin
      xlate_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      ctrl_o  <= head_i;
      paddr_o <= head_i.vaddr;
      ex_o    <= ex_d;
    end
  end

endmodule

`default_nettype wire

//--- source/lsu_agu.sv
/*
  Address generation unit
  Forms the virtual address from base plus signed immediate, the byte
  enables for the transfer and the lane-aligned store data
*/
`timescale 1ns/10ps
`default_nettype none

module lsu_agu (
  input  lsu_pkg::lsu_req_t  req_i,
  output lsu_pkg::lsu_ctrl_t ctrl_o
);
  import lsu_pkg::*;

  logic [XLEN-1:0]   vaddr;
  logic [1:0]        offset;
  logic [XLEN/8-1:0] be;

  // Immediate is already sign extended to XLEN
  assign vaddr  = $unsigned($signed(req_i.operand_a) + $signed(req_i.imm));
  assign offset = vaddr[1:0];

  // ----------------------------------------
  // Byte enables
  // ----------------------------------------
  always_comb begin
    case (op_size(req_i.op))
      2'd0:    be = 4'b0001 << offset;
      2'd1:    be = 4'b0011 << offset;
      default: be = 4'b1111;
    endcase
  end

  always_comb begin
    ctrl_o.vaddr    = vaddr;
    // Store data moved into the addressed byte lanes
    ctrl_o.wdata    = req_i.operand_b << {offset, 3'b000};
    ctrl_o.be       = be;
    ctrl_o.op       = req_i.op;
    ctrl_o.trans_id = req_i.trans_id;
  end

endmodule

`default_nettype wire

//--- source/lsu_ctrl_queue.sv
/*
  Two-entry request buffer
  Holds control entries between address generation and translation,
  passes an entry straight through when empty and drives the ready
*/
`timescale 1ns/10ps
`default_nettype none

module lsu_ctrl_queue (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               push_i,
  input  lsu_pkg::lsu_ctrl_t ctrl_i,
  input  logic               pop_i,
  output logic               ready_o,
  output logic               head_valid_o,
  output lsu_pkg::lsu_ctrl_t head_o
);
  import lsu_pkg::*;

  lsu_ctrl_t  mem_q [2];
  logic       rd_ptr_q;
  logic       wr_ptr_q;
  logic [1:0] count_q;
  logic       empty;
  logic       wr_en;
  logic       rd_en;

  assign empty        = (count_q == 2'd0);
  assign ready_o      = (count_q != 2'd2);
  assign head_valid_o = !empty || push_i;
  assign head_o       = empty ? ctrl_i : mem_q[rd_ptr_q];

  // Bypassed entry is never written
  assign wr_en = push_i && ready_o && !(empty && pop_i);
  assign rd_en = pop_i && !empty;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= 1'b0;
      wr_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (rd_en) begin
        rd_ptr_q <= !rd_ptr_q;
      end
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= ctrl_i;
    end
  end

endmodule

`default_nettype wire

//--- source/lsu_result_pipe.sv
/*
  Result pipeline register chain
  Delays one result path by DEPTH cycles, a plain wire at depth zero
*/
`timescale 1ns/10ps
`default_nettype none

module lsu_result_pipe #(
  parameter int unsigned DEPTH = 1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  lsu_pkg::lsu_result_t d_i,
  output lsu_pkg::lsu_result_t d_o
);
  import lsu_pkg::*;

  if (DEPTH == 0) begin : gen_wire
    assign d_o = d_i;
  end else begin : gen_regs
    logic [DEPTH-1:0] valid_q;
    lsu_result_t      data_q [DEPTH];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q <= '0;
      end else begin
        valid_q[0] <= d_i.valid;
        for (int i = 1; i < DEPTH; i++) begin
          valid_q[i] <= valid_q[i-1];
        end
      end
    end

    always_ff @(posedge clk_i) begin
      data_q[0] <= d_i;
      for (int i = 1; i < DEPTH; i++) begin
        data_q[i] <= data_q[i-1];
      end
    end

    // Valid from the reset chain, payload from the data chain
    always_comb begin
      d_o       = data_q[DEPTH-1];
      d_o.valid = valid_q[DEPTH-1];
    end
  end

endmodule

`default_nettype wire

//--- source/lsu_top.sv
/*
  Load/store unit top level
  Address generation, request buffer, no-MMU translation, memory
  issue with credit flow control, and the load and store result pipes
*/
`timescale 1ns/10ps
`default_nettype none

module lsu_top #(
  parameter int unsigned NUM_CREDITS      = 2,
  parameter int unsigned LOAD_PIPE_DEPTH  = 1,
  parameter int unsigned STORE_PIPE_DEPTH = 0
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 lsu_valid_i,
  input  lsu_pkg::lsu_req_t    lsu_req_i,
  output logic                 lsu_ready_o,
  output mem_pkg::mem_req_t    mem_req_o,
  input  mem_pkg::mem_rsp_t    mem_rsp_i,
  input  logic                 mem_credit_i,
  output lsu_pkg::lsu_result_t load_result_o,
  output lsu_pkg::lsu_result_t store_result_o
);
  import lsu_pkg::*;

  lsu_ctrl_t       agu_ctrl;
  lsu_ctrl_t       head;
  logic            head_valid;
  logic            pop;
  logic            issue_ready;
  logic            xlate_valid;
  lsu_ctrl_t       xlate_ctrl;
  logic [XLEN-1:0] paddr;
  exception_t      xlate_ex;
  lsu_result_t     ld_result;
  lsu_result_t     st_result;

  lsu_agu u_agu (
    .req_i  (lsu_req_i),
    .ctrl_o (agu_ctrl)
  );

  lsu_ctrl_queue u_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (lsu_valid_i),
    .ctrl_i       (agu_ctrl),
    .pop_i        (pop),
    .ready_o      (lsu_ready_o),
    .head_valid_o (head_valid),
    .head_o       (head)
  );

  lsu_addr_xlate u_xlate (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .head_valid_i  (head_valid),
    .head_i        (head),
    .pop_o         (pop),
    .issue_ready_i (issue_ready),
    .xlate_valid_o (xlate_valid),
    .ctrl_o        (xlate_ctrl),
    .paddr_o       (paddr),
    .ex_o          (xlate_ex)
  );

  lsu_mem_issue #(
    .NUM_CREDITS (NUM_CREDITS)
  ) u_issue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .xlate_valid_i (xlate_valid),
    .ctrl_i        (xlate_ctrl),
    .paddr_i       (paddr),
    .ex_i          (xlate_ex),
    .issue_ready_o (issue_ready),
    .mem_req_o     (mem_req_o),
    .mem_rsp_i     (mem_rsp_i),
    .mem_credit_i  (mem_credit_i),
    .ld_result_o   (ld_result),
    .st_result_o   (st_result)
  );

  // ----------------------------------------
  // Result pipes
  // ----------------------------------------
  lsu_result_pipe #(
    .DEPTH (LOAD_PIPE_DEPTH)
  ) u_load_pipe (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (ld_result),
    .d_o    (load_result_o)
  );

  lsu_result_pipe #(
    .DEPTH (STORE_PIPE_DEPTH)
  ) u_store_pipe (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (st_result),
    .d_o    (store_result_o)
  );

endmodule

`default_nettype wire
